/* Bender.yml */
package:
  name: tlu_controller

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - tlu_cfg_pkg.sv
      - tlu_fsm_pkg.sv
      - trigger_input_stage.sv
      - tlu_handshake_fsm.sv
      - trigger_word_builder.sv
      - tlu_controller.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_tlu_model.sv
      - tb_tlu_controller.sv

/* list.f */
+incdir+.
tlu_cfg_pkg.sv
tlu_fsm_pkg.sv
trigger_input_stage.sv
tlu_handshake_fsm.sv
trigger_word_builder.sv
tlu_controller.sv
tb_tlu_model.sv
tb_tlu_controller.sv

/* tb_tlu_controller.sv */
// TLU controller testbench
// external, TLU handshake and TLU data modes, acknowledge ordering,
// vetoes, time-out and all three word formats against a scoreboard
`include "tlu_consts.svh"

module tb_tlu_controller;

    localparam int TEST_CYCLES = 600; // summed worst case of all tests
    localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

    logic        TRIGGER_CLK = 1'b0;
    logic        RESET;
    logic        ext_trigger;
    logic        use_model;
    logic        trigger;
    logic        trigger_enable;
    logic        trigger_veto;
    logic        trigger_acknowledge;
    logic        fifo_acknowledge;
    tlu_cfg_pkg::trigger_mode_e trigger_mode;
    tlu_cfg_pkg::data_format_e  data_format;
    logic [3:0]  tlu_trigger_data_delay;
    logic [7:0]  tlu_low_time_out;
    logic        tlu_data_msb_first;
    logic        tlu_reset_flag;
    logic        counter_set;
    logic [31:0] counter_set_value;
    logic [31:0] trigger_data;
    logic        trigger_data_write;
    logic        trigger_accepted_flag;
    logic [31:0] timestamp;
    logic        tlu_busy;
    logic        fifo_preempt_req;
    logic        tlu_clock_enable;
    logic        low_timeout_error_flag;

    logic        model_start;
    logic [15:0] model_number;
    logic [7:0]  model_hold;
    logic        model_with_data;
    logic        model_trigger;
    logic        model_active;

    logic [31:0] rng_state = 32'h606e_77e7;
    logic [31:0] expected_q[$];
    logic [31:0] exp_word;
    logic [31:0] exp_count;
    logic [31:0] rnd;
    int          cycles;
    int          write_count;
    int          accept_count;
    int          flag_count;
    int          expected_accepts;
    logic        prev_accept;
    logic        prev_flag;

    always #5 TRIGGER_CLK = ~TRIGGER_CLK;

    assign trigger = use_model ? model_trigger : ext_trigger;

    tlu_controller i_dut (.*);

    tb_tlu_model i_tlu (
        .TRIGGER_CLK      (TRIGGER_CLK),
        .tlu_clock_enable (tlu_clock_enable),
        .start            (model_start),
        .number           (model_number),
        .hold_cycles      (model_hold),
        .with_data        (model_with_data),
        .msb_first        (tlu_data_msb_first),
        .trigger          (model_trigger),
        .active           (model_active)
    );

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic fail_text(input string msg);
        $display("error at t=%0t: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    always @(posedge TRIGGER_CLK)
    begin
        cycles++;
        if (cycles > MAX_CYCLES)
            fail_text("run did not finish within the cycle limit");
    end

    // scoreboard and protocol checks on the falling edge
    always @(negedge TRIGGER_CLK)
    begin
        if (!RESET)
        begin
            if (trigger_data_write)
            begin
                write_count++;
                if (expected_q.size() == 0)
                    fail_text("trigger word written with none expected");
                else
                begin
                    exp_word = expected_q.pop_front();
                    assert (trigger_data == exp_word)
                        else fail_value("trigger_data", exp_word, trigger_data);
                end
            end
            if (trigger_mode == tlu_cfg_pkg::MODE_EXTERNAL)
                assert (trigger_data_write == prev_accept)
                    else fail_value("trigger_data_write", prev_accept, trigger_data_write);
            assert (!(low_timeout_error_flag && prev_flag))
                else fail_text("time-out flag high for more than one cycle");
            if (trigger_accepted_flag)
                accept_count++;
            if (low_timeout_error_flag)
                flag_count++;
        end
        prev_accept = trigger_accepted_flag;
        prev_flag   = low_timeout_error_flag;
    end

    task automatic wait_for_write(input int writes_before);
        while (write_count == writes_before)
            @(posedge TRIGGER_CLK);
        #1;
    endtask

    // both acknowledges in random order with a random gap
    task automatic acknowledge_trigger();
        logic fifo_first;
        int   gap;
        rnd        = next_random();
        fifo_first = rnd[0];
        gap        = rnd[2:1];
        if (fifo_first)
            fifo_acknowledge = 1'b1;
        else
            trigger_acknowledge = 1'b1;
        @(posedge TRIGGER_CLK);
        #1;
        fifo_acknowledge    = 1'b0;
        trigger_acknowledge = 1'b0;
        repeat (gap + 1)
        begin
            assert (tlu_busy) else fail_value("tlu_busy", 1, tlu_busy);
            assert (fifo_preempt_req) else fail_value("fifo_preempt_req", 1, fifo_preempt_req);
            @(posedge TRIGGER_CLK);
            #1;
        end
        if (fifo_first)
            trigger_acknowledge = 1'b1;
        else
            fifo_acknowledge = 1'b1;
        @(posedge TRIGGER_CLK);
        #1;
        fifo_acknowledge    = 1'b0;
        trigger_acknowledge = 1'b0;
        assert (tlu_busy) else fail_value("tlu_busy", 1, tlu_busy);
        assert (fifo_preempt_req) else fail_value("fifo_preempt_req", 1, fifo_preempt_req);
        @(posedge TRIGGER_CLK);
        #1;
        assert (!tlu_busy) else fail_value("tlu_busy", 0, tlu_busy);
        assert (!fifo_preempt_req) else fail_value("fifo_preempt_req", 0, fifo_preempt_req);
    endtask

    task automatic pulse_external();
        @(posedge TRIGGER_CLK);
        #1 ext_trigger = 1'b1;
        @(posedge TRIGGER_CLK);
        #1 ext_trigger = 1'b0;
    endtask

    task automatic external_cycle(input logic extra_pulse);
        int writes_before;
        writes_before = write_count;
        @(posedge TRIGGER_CLK);
        #1 ext_trigger = 1'b1; // timestamp now is what the edge captures
        case (data_format)
            tlu_cfg_pkg::FMT_TIMESTAMP:
                expected_q.push_back({1'b1, timestamp[30:0]});
            tlu_cfg_pkg::FMT_COMBINED:
                expected_q.push_back({1'b1, timestamp[14:0], exp_count[15:0]});
            default:
                expected_q.push_back({1'b1, exp_count[30:0]});
        endcase
        exp_count++;
        expected_accepts++;
        @(posedge TRIGGER_CLK);
        #1 ext_trigger = 1'b0;
        wait_for_write(writes_before);
        if (extra_pulse)
            pulse_external(); // ignored while the acks are missing
        acknowledge_trigger();
    endtask

    task automatic tlu_cycle(input logic [15:0] number, input logic with_data,
                             input logic [7:0] hold, input logic check_busy);
        int writes_before;
        int accepts;
        writes_before = write_count;
        accepts       = accept_count;
        if (with_data)
            expected_q.push_back({1'b1, 15'd0, number});
        else
            expected_q.push_back({1'b1, exp_count[30:0]});
        exp_count++;
        expected_accepts++;
        model_number    = number;
        model_hold      = hold;
        model_with_data = with_data;
        model_start     = 1'b1;
        @(posedge TRIGGER_CLK);
        #1 model_start = 1'b0;
        if (check_busy)
        begin
            while (accept_count == accepts)
                @(posedge TRIGGER_CLK);
            #1;
            while (model_trigger)
            begin
                assert (tlu_busy) else fail_value("tlu_busy", 1, tlu_busy);
                @(posedge TRIGGER_CLK);
                #1;
            end
        end
        wait_for_write(writes_before);
        acknowledge_trigger();
        while (model_active)
            @(posedge TRIGGER_CLK);
        #1;
    endtask

    initial
    begin
        RESET                  = 1'b1;
        ext_trigger            = 1'b0;
        use_model              = 1'b0;
        trigger_enable         = 1'b0;
        trigger_veto           = 1'b0;
        trigger_acknowledge    = 1'b0;
        fifo_acknowledge       = 1'b0;
        trigger_mode           = tlu_cfg_pkg::MODE_EXTERNAL;
        data_format            = tlu_cfg_pkg::FMT_TRIGGER_NUMBER;
        tlu_trigger_data_delay = 4'd8; // aligns sampling to bit window centres
        tlu_low_time_out       = 8'd0;
        tlu_data_msb_first     = 1'b0;
        tlu_reset_flag         = 1'b0;
        counter_set            = 1'b0;
        counter_set_value      = 32'd0;
        model_start            = 1'b0;
        model_number           = 16'd0;
        model_hold             = 8'd0;
        model_with_data        = 1'b0;
        cycles                 = 0;
        write_count            = 0;
        accept_count           = 0;
        flag_count             = 0;
        expected_accepts       = 0;
        prev_accept            = 1'b0;
        prev_flag              = 1'b0;

        repeat (16) @(posedge TRIGGER_CLK);
        #1 RESET = 1'b0;
        assert (!(trigger_data_write | trigger_accepted_flag | tlu_busy | fifo_preempt_req |
                  tlu_clock_enable | low_timeout_error_flag))
            else fail_text("outputs not low after reset");

        counter_set_value = next_random();
        exp_count         = counter_set_value;
        counter_set       = 1'b1;
        @(posedge TRIGGER_CLK);
        #1 counter_set = 1'b0;
        trigger_enable = 1'b1;

        external_cycle(1'b0);
        external_cycle(1'b1);
        external_cycle(1'b0);

        // vetoed, disabled and unacknowledged triggers
        trigger_veto = 1'b1;
        pulse_external();
        trigger_veto   = 1'b0;
        trigger_enable = 1'b0;
        pulse_external();
        trigger_enable   = 1'b1;
        fifo_acknowledge = 1'b1;
        pulse_external();
        fifo_acknowledge = 1'b0;
        repeat (3) @(posedge TRIGGER_CLK);
        #1;
        assert (accept_count == expected_accepts)
            else fail_value("trigger_accepted_flag count", expected_accepts, accept_count);

        data_format = tlu_cfg_pkg::FMT_TIMESTAMP;
        external_cycle(1'b0);
        data_format = tlu_cfg_pkg::FMT_COMBINED;
        external_cycle(1'b0);
        data_format = tlu_cfg_pkg::FMT_TRIGGER_NUMBER;

        tlu_reset_flag = 1'b1;
        @(posedge TRIGGER_CLK);
        #1 tlu_reset_flag = 1'b0;
        assert (timestamp == 32'd0) else fail_value("timestamp", 0, timestamp);
        @(posedge TRIGGER_CLK);
        #1;
        assert (timestamp == 32'd1) else fail_value("timestamp", 1, timestamp);

        use_model    = 1'b1;
        trigger_mode = tlu_cfg_pkg::MODE_TLU_NO_DATA;
        tlu_cycle(16'd0, 1'b0, 8'd30, 1'b1);
        tlu_low_time_out = 8'd20; // trigger held well past it
        tlu_cycle(16'd0, 1'b0, 8'd60, 1'b0);
        assert (flag_count == 1) else fail_value("low_timeout_error_flag count", 1, flag_count);
        tlu_low_time_out = 8'd0;

        trigger_mode = tlu_cfg_pkg::MODE_TLU_DATA;
        rnd = next_random();
        tlu_cycle(rnd[15:0], 1'b1, 8'd10, 1'b0);
        tlu_data_msb_first = 1'b1;
        rnd = next_random();
        tlu_cycle(rnd[15:0], 1'b1, 8'd10, 1'b0);

        repeat (4) @(posedge TRIGGER_CLK);
        #1;
        assert (accept_count == expected_accepts)
            else fail_value("trigger_accepted_flag count", expected_accepts, accept_count);
        assert (expected_q.size() == 0) else fail_text("expected trigger word never written");
        $display("TEST OK");
        $finish;
    end

endmodule

/* tb_tlu_model.sv */
// behavioral TLU
// raises trigger on request, drops it after a hold time and then
// shifts the trigger number out during the TLU clock burst
`include "tlu_consts.svh"

module tb_tlu_model (
    input  logic                         TRIGGER_CLK,
    input  logic                         tlu_clock_enable,
    input  logic                         start,
    input  logic [`TLU_NUMBER_BITS-1:0]  number,
    input  logic [7:0]                   hold_cycles,
    input  logic                         with_data,
    input  logic                         msb_first,
    output logic                         trigger,
    output logic                         active
);

    int cycle_idx; // cycles into the burst
    int window;

    initial
    begin
        trigger = 1'b0;
        active  = 1'b0;
        forever
        begin
            @(posedge TRIGGER_CLK);
            if (start)
            begin
                active = 1'b1;
                #1 trigger = 1'b1;
                repeat (hold_cycles) @(posedge TRIGGER_CLK);
                #1 trigger = 1'b0;
                cycle_idx = 0;
                while (with_data)
                begin
                    @(posedge TRIGGER_CLK);
                    #1;
                    if (tlu_clock_enable)
                    begin
                        window = cycle_idx / `TLU_CLOCK_DIVISOR;
                        if (window == 0)
                            trigger = 1'b0; // first bit clock carries no data
                        else if (msb_first)
                            trigger = number[`TLU_NUMBER_BITS - window];
                        else
                            trigger = number[window - 1];
                        cycle_idx++;
                    end
                    else if (cycle_idx > 0)
                    begin
                        trigger = 1'b0;
                        break;
                    end
                end
                active = 1'b0;
            end
        end
    end

endmodule

/* tlu_cfg_pkg.sv */
// TLU controller configuration types
// trigger mode and output data format as seen on the config ports
package tlu_cfg_pkg;

    // 2'b01 is unused and handled like the plain external trigger
    typedef enum logic [1:0]
    {
        MODE_EXTERNAL    = 2'b00, // accept on rising edge of trigger
        MODE_TLU_NO_DATA = 2'b10, // busy handshake only
        MODE_TLU_DATA    = 2'b11  // handshake plus serial trigger number
    } trigger_mode_e;

    typedef enum logic [1:0]
    {
        FMT_TRIGGER_NUMBER = 2'b00, // counter or TLU number
        FMT_TIMESTAMP      = 2'b01, // timestamp only
        FMT_COMBINED       = 2'b10  // timestamp upper half, number lower half
    } data_format_e;

endpackage

/* tlu_consts.svh */
// TLU controller constants
// bit clock divisor, readout length, word widths and the
// extra sync wait used before the trigger number is latched
`ifndef TLU_CONSTS_SVH
`define TLU_CONSTS_SVH

// system clock cycles per TLU bit clock
`define TLU_CLOCK_DIVISOR 8

// TLU bit clocks per readout, first one carries no data
`define TLU_CLOCK_CYCLES 17

// recovered trigger number width
`define TLU_NUMBER_BITS (`TLU_CLOCK_CYCLES - 1)

// sampling shift register, one sample per system cycle of the burst
`define TLU_SR_WIDTH (`TLU_CLOCK_CYCLES * `TLU_CLOCK_DIVISOR)

`define TRIGGER_WORD_WIDTH 32

// wait cycles on top of the data delay before latching
`define TLU_SYNC_MARGIN 5

`endif

/* tlu_controller.sv */
// TLU controller top
// input stage, handshake FSM and trigger word builder; one tagged
// trigger word is written per accepted trigger
`include "tlu_consts.svh"

module tlu_controller (
    input  logic                            TRIGGER_CLK,
    input  logic                            RESET,
    input  logic                            trigger,
    input  logic                            trigger_enable,
    input  logic                            trigger_veto,
    input  logic                            trigger_acknowledge,
    input  logic                            fifo_acknowledge,
    input  tlu_cfg_pkg::trigger_mode_e      trigger_mode,
    input  tlu_cfg_pkg::data_format_e       data_format,
    input  logic [3:0]                      tlu_trigger_data_delay,
    input  logic [7:0]                      tlu_low_time_out,
    input  logic                            tlu_data_msb_first,
    input  logic                            tlu_reset_flag,
    input  logic                            counter_set,
    input  logic [`TRIGGER_WORD_WIDTH-1:0]  counter_set_value,
    output logic [`TRIGGER_WORD_WIDTH-1:0]  trigger_data,
    output logic                            trigger_data_write,
    output logic                            trigger_accepted_flag,
    output logic [`TRIGGER_WORD_WIDTH-1:0]  timestamp,
    output logic                            tlu_busy,
    output logic                            fifo_preempt_req,
    output logic                            tlu_clock_enable,
    output logic                            low_timeout_error_flag
);

    logic                     trigger_rise;
    logic                     enable_rise;
    logic                     trigger_level;
    logic [`TLU_SR_WIDTH-1:0] sample_sr;
    logic                     accept_pulse;
    logic                     capture_timestamp;
    logic                     latch_pulse;

    trigger_input_stage i_input_stage (
        .TRIGGER_CLK    (TRIGGER_CLK),
        .RESET          (RESET),
        .trigger        (trigger),
        .trigger_enable (trigger_enable),
        .accept_pulse   (accept_pulse),
        .trigger_rise   (trigger_rise),
        .enable_rise    (enable_rise),
        .trigger_level  (trigger_level),
        .sample_sr      (sample_sr)
    );

    tlu_handshake_fsm i_fsm (
        .TRIGGER_CLK            (TRIGGER_CLK),
        .RESET                  (RESET),
        .trigger_rise           (trigger_rise),
        .enable_rise            (enable_rise),
        .trigger_level          (trigger_level),
        .trigger_enable         (trigger_enable),
        .trigger_veto           (trigger_veto),
        .trigger_acknowledge    (trigger_acknowledge),
        .fifo_acknowledge       (fifo_acknowledge),
        .trigger_mode           (trigger_mode),
        .tlu_trigger_data_delay (tlu_trigger_data_delay),
        .tlu_low_time_out       (tlu_low_time_out),
        .accept_pulse           (accept_pulse),
        .capture_timestamp      (capture_timestamp),
        .latch_pulse            (latch_pulse),
        .tlu_busy               (tlu_busy),
        .fifo_preempt_req       (fifo_preempt_req),
        .tlu_clock_enable       (tlu_clock_enable),
        .low_timeout_error_flag (low_timeout_error_flag)
    );

    trigger_word_builder i_builder (
        .TRIGGER_CLK        (TRIGGER_CLK),
        .RESET              (RESET),
        .sample_sr          (sample_sr),
        .accept_pulse       (accept_pulse),
        .capture_timestamp  (capture_timestamp),
        .latch_pulse        (latch_pulse),
        .tlu_reset_flag     (tlu_reset_flag),
        .counter_set        (counter_set),
        .counter_set_value  (counter_set_value),
        .tlu_data_msb_first (tlu_data_msb_first),
        .trigger_mode       (trigger_mode),
        .data_format        (data_format),
        .trigger_data       (trigger_data),
        .timestamp          (timestamp)
    );

    assign trigger_data_write    = latch_pulse;
    assign trigger_accepted_flag = accept_pulse;

endmodule

/* tlu_fsm_pkg.sv */
// TLU handshake control types
// state encoding of the handshake FSM
package tlu_fsm_pkg;

    typedef enum logic [2:0]
    {
        ST_IDLE              = 3'b000,
        ST_SEND_COMMAND      = 3'b001, // external trigger, no wait
        ST_WAIT_TRIGGER_LOW  = 3'b010, // TLU holds trigger until busy seen
        ST_SEND_TLU_CLOCK    = 3'b011, // clock burst for the trigger number
        ST_WAIT_BEFORE_LATCH = 3'b100, // cable delay and sync
        ST_LATCH_DATA        = 3'b101, // one cycle, word written
        ST_WAIT_ACK          = 3'b110  // until both acknowledges seen
    } tlu_state_e;

endpackage

/* tlu_handshake_fsm.sv */
// TLU handshake FSM
// accepts a trigger, runs the TLU busy handshake and clock burst,
// waits the data delay, latches the word and then holds until the
// trigger and FIFO acknowledges have both been seen
`include "tlu_consts.svh"

module tlu_handshake_fsm (
    input  logic                        TRIGGER_CLK,
    input  logic                        RESET,
    input  logic                        trigger_rise,
    input  logic                        enable_rise,
    input  logic                        trigger_level,
    input  logic                        trigger_enable,
    input  logic                        trigger_veto,
    input  logic                        trigger_acknowledge,
    input  logic                        fifo_acknowledge,
    input  tlu_cfg_pkg::trigger_mode_e  trigger_mode,
    input  logic [3:0]                  tlu_trigger_data_delay,
    input  logic [7:0]                  tlu_low_time_out,
    output logic                        accept_pulse,
    output logic                        capture_timestamp,
    output logic                        latch_pulse,
    output logic                        tlu_busy,
    output logic                        fifo_preempt_req,
    output logic                        tlu_clock_enable,
    output logic                        low_timeout_error_flag
);

    localparam int CLK_CNT_W = $clog2(`TLU_SR_WIDTH);

    tlu_fsm_pkg::tlu_state_e state;
    tlu_fsm_pkg::tlu_state_e state_next;

    logic [CLK_CNT_W-1:0] clk_cnt;     // cycles into the clock burst
    logic [4:0]           wait_cnt;    // cycles into the latch wait
    logic [4:0]           wait_target;
    logic [7:0]           timeout_cnt; // cycles waiting for trigger low
    logic                 timeout_hit;
    logic                 trigger_acked;
    logic                 fifo_acked;
    logic                 start_ok;
    logic                 tlu_mode;
    logic                 busy_q;

    // no new trigger while the previous one is still being acknowledged
    assign start_ok = trigger_enable & ~trigger_acknowledge & ~fifo_acknowledge;

    assign tlu_mode = (trigger_mode == tlu_cfg_pkg::MODE_TLU_NO_DATA) ||
                      (trigger_mode == tlu_cfg_pkg::MODE_TLU_DATA);

    assign wait_target = 5'(tlu_trigger_data_delay) + 5'(`TLU_SYNC_MARGIN - 1);

    // zero time-out disables the check
    assign timeout_hit = trigger_level && (tlu_low_time_out != 8'd0) &&
                         (timeout_cnt == tlu_low_time_out);

    // timestamp follows every trigger edge seen in idle, accepted or not
    assign capture_timestamp = (state == tlu_fsm_pkg::ST_IDLE) && trigger_rise;

    always_comb
    begin
        state_next = state;
        case (state)
            tlu_fsm_pkg::ST_IDLE:
            begin
                if (tlu_mode)
                begin
                    // TLU may already hold trigger high when enabled
                    if (start_ok && (trigger_rise || (trigger_level && enable_rise)))
                        state_next = tlu_fsm_pkg::ST_WAIT_TRIGGER_LOW;
                end
                else if (start_ok && trigger_rise && !trigger_veto)
                begin
                    state_next = tlu_fsm_pkg::ST_SEND_COMMAND;
                end
            end
            tlu_fsm_pkg::ST_SEND_COMMAND:
            begin
                state_next = tlu_fsm_pkg::ST_LATCH_DATA;
            end
            tlu_fsm_pkg::ST_WAIT_TRIGGER_LOW:
            begin
                if (!trigger_level || timeout_hit)
                begin
                    if (trigger_mode == tlu_cfg_pkg::MODE_TLU_DATA)
                        state_next = tlu_fsm_pkg::ST_SEND_TLU_CLOCK;
                    else
                        state_next = tlu_fsm_pkg::ST_LATCH_DATA;
                end
            end
            tlu_fsm_pkg::ST_SEND_TLU_CLOCK:
            begin
                if (clk_cnt == CLK_CNT_W'(`TLU_SR_WIDTH - 1))
                    state_next = tlu_fsm_pkg::ST_WAIT_BEFORE_LATCH;
            end
            tlu_fsm_pkg::ST_WAIT_BEFORE_LATCH:
            begin
                if (wait_cnt == wait_target)
                    state_next = tlu_fsm_pkg::ST_LATCH_DATA;
            end
            tlu_fsm_pkg::ST_LATCH_DATA:
            begin
                state_next = tlu_fsm_pkg::ST_WAIT_ACK;
            end
            tlu_fsm_pkg::ST_WAIT_ACK:
            begin
                if (trigger_acked && fifo_acked)
                    state_next = tlu_fsm_pkg::ST_IDLE;
            end
            default:
            begin
                state_next = tlu_fsm_pkg::ST_IDLE;
            end
        endcase
    end

    // outputs registered from the next state so they line up with state
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
        begin
            state                  <= tlu_fsm_pkg::ST_IDLE;
            accept_pulse           <= 1'b0;
            latch_pulse            <= 1'b0;
            busy_q                 <= 1'b0;
            tlu_clock_enable       <= 1'b0;
            low_timeout_error_flag <= 1'b0;
            clk_cnt                <= '0;
            wait_cnt               <= '0;
            timeout_cnt            <= '0;
            trigger_acked          <= 1'b0;
            fifo_acked             <= 1'b0;
        end
        else
        begin
            state <= state_next;
            accept_pulse <= (state == tlu_fsm_pkg::ST_IDLE) &&
                            (state_next != tlu_fsm_pkg::ST_IDLE);
            latch_pulse      <= state_next == tlu_fsm_pkg::ST_LATCH_DATA;
            busy_q           <= state_next != tlu_fsm_pkg::ST_IDLE;
            tlu_clock_enable <= state_next == tlu_fsm_pkg::ST_SEND_TLU_CLOCK;
            // leaves the wait state on the hit, so a single pulse
            low_timeout_error_flag <= (state == tlu_fsm_pkg::ST_WAIT_TRIGGER_LOW) &&
                                      timeout_hit;

            if (state == tlu_fsm_pkg::ST_WAIT_TRIGGER_LOW)
                timeout_cnt <= timeout_cnt + 8'd1;
            else
                timeout_cnt <= '0;

            if (state == tlu_fsm_pkg::ST_SEND_TLU_CLOCK)
                clk_cnt <= clk_cnt + 1'b1;
            else
                clk_cnt <= '0;

            if (state == tlu_fsm_pkg::ST_WAIT_BEFORE_LATCH)
                wait_cnt <= wait_cnt + 5'd1;
            else
                wait_cnt <= '0;

            // sticky acknowledges, armed once the trigger is accepted
            if (state == tlu_fsm_pkg::ST_IDLE)
            begin
                trigger_acked <= 1'b0;
                fifo_acked    <= 1'b0;
            end
            else
            begin
                if (trigger_acknowledge)
                    trigger_acked <= 1'b1;
                if (fifo_acknowledge)
                    fifo_acked <= 1'b1;
            end
        end
    end

    assign tlu_busy         = busy_q;
    assign fifo_preempt_req = busy_q; // FIFO held for the whole handshake

endmodule

/* trigger_input_stage.sv */
// TLU trigger input stage
// edge detection on trigger and trigger enable, and the raw sampling
// shift register used to recover the serial trigger number
`include "tlu_consts.svh"

module trigger_input_stage (
    input  logic                       TRIGGER_CLK,
    input  logic                       RESET,
    input  logic                       trigger,
    input  logic                       trigger_enable,
    input  logic                       accept_pulse,
    output logic                       trigger_rise,
    output logic                       enable_rise,
    output logic                       trigger_level,
    output logic [`TLU_SR_WIDTH-1:0]   sample_sr
);

    logic trigger_q; // previous cycle level
    logic enable_q;

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
        begin
            trigger_q <= 1'b0;
            enable_q  <= 1'b0;
        end
        else
        begin
            trigger_q <= trigger;
            enable_q  <= trigger_enable;
        end
    end

    assign trigger_rise  = trigger & ~trigger_q;
    assign enable_rise   = trigger_enable & ~enable_q;
    assign trigger_level = trigger;

    // newest sample in bit 0, cleared when a trigger is accepted
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET || accept_pulse)
        begin
            sample_sr <= '0;
        end
        else
        begin
            sample_sr <= {sample_sr[`TLU_SR_WIDTH-2:0], trigger};
        end
    end

endmodule

/* trigger_word_builder.sv */
// trigger word builder
// timestamp and trigger counter, serial trigger number recovery from
// the sampling register and the output word format mux
`include "tlu_consts.svh"

module trigger_word_builder (
    input  logic                            TRIGGER_CLK,
    input  logic                            RESET,
    input  logic [`TLU_SR_WIDTH-1:0]        sample_sr,
    input  logic                            accept_pulse,
    input  logic                            capture_timestamp,
    input  logic                            latch_pulse,
    input  logic                            tlu_reset_flag,
    input  logic                            counter_set,
    input  logic [`TRIGGER_WORD_WIDTH-1:0]  counter_set_value,
    input  logic                            tlu_data_msb_first,
    input  tlu_cfg_pkg::trigger_mode_e      trigger_mode,
    input  tlu_cfg_pkg::data_format_e       data_format,
    output logic [`TRIGGER_WORD_WIDTH-1:0]  trigger_data,
    output logic [`TRIGGER_WORD_WIDTH-1:0]  timestamp
);

    localparam int HALF = `TRIGGER_WORD_WIDTH / 2;

    logic [`TRIGGER_WORD_WIDTH-1:0] trig_cnt;
    logic [`TRIGGER_WORD_WIDTH-1:0] cnt_snapshot;
    logic [`TRIGGER_WORD_WIDTH-1:0] ts_capture;
    logic [`TLU_NUMBER_BITS-1:0]    recovered;
    logic [`TLU_NUMBER_BITS-1:0]    number_reg;
    logic [`TLU_NUMBER_BITS-1:0]    number_word;
    logic [`TRIGGER_WORD_WIDTH-1:0] base_word;

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET || tlu_reset_flag)
            timestamp <= '0;
        else
            timestamp <= timestamp + 1'b1;
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
            trig_cnt <= '0;
        else if (counter_set)
            trig_cnt <= counter_set_value;
        else if (accept_pulse)
            trig_cnt <= trig_cnt + 1'b1;
    end

    // snapshot takes the count before this trigger's increment
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (accept_pulse)
            cnt_snapshot <= trig_cnt;
        if (capture_timestamp)
            ts_capture <= timestamp;
        if (latch_pulse)
            number_reg <= recovered;
    end

    // one sample per divisor window, oldest window first
    always_comb
    begin
        recovered = '0;
        for (int j = 0; j < `TLU_NUMBER_BITS; j++)
        begin
            if (tlu_data_msb_first)
                recovered[`TLU_NUMBER_BITS-1-j] =
                    sample_sr[(`TLU_CLOCK_CYCLES - j) * `TLU_CLOCK_DIVISOR - 1];
            else
                recovered[j] =
                    sample_sr[(`TLU_CLOCK_CYCLES - j) * `TLU_CLOCK_DIVISOR - 1];
        end
    end

    // valid already in the write cycle, held afterwards
    assign number_word = latch_pulse ? recovered : number_reg;

    always_comb
    begin
        if (trigger_mode == tlu_cfg_pkg::MODE_TLU_DATA)
            base_word = {1'b1, {(`TRIGGER_WORD_WIDTH - 1 - `TLU_NUMBER_BITS){1'b0}},
                         number_word};
        else
            base_word = {1'b1, cnt_snapshot[`TRIGGER_WORD_WIDTH-2:0]};

        case (data_format)
            tlu_cfg_pkg::FMT_TIMESTAMP:
                trigger_data = {1'b1, ts_capture[`TRIGGER_WORD_WIDTH-2:0]};
            tlu_cfg_pkg::FMT_COMBINED:
                trigger_data = {1'b1, ts_capture[HALF-2:0], base_word[HALF-1:0]};
            default:
                trigger_data = base_word;
        endcase
    end

endmodule
